/* verilog/qe_pkg.sv */
// shared register map, config fields, FSM encodings and limits, imported by every qe block
package qe_pkg;

	// host data word
	typedef logic [31:0] word_t;

	//////////////////////////////////////////////////////////////////////
	// register map
	//////////////////////////////////////////////////////////////////////

	// eight register slots per channel
	localparam int REGS_PER_CHANNEL = 8;
	localparam int OFFSET_W = $clog2(REGS_PER_CHANNEL);
	// host address width
	localparam int ADDR_W = 6;

	// register offsets inside one channel
	typedef enum logic [OFFSET_W-1:0] {
		REG_COUNT          = 3'd0,
		REG_TURNS          = 3'd1,
		REG_SPEED          = 3'd2,
		REG_PHASE_TIME     = 3'd3,
		REG_COUNTS_PER_REV = 3'd4,
		REG_CONFIG         = 3'd5,
		REG_STATUS         = 3'd6,
		REG_UNUSED         = 3'd7
	} qe_reg_t;

	//////////////////////////////////////////////////////////////////////
	// config register bits
	//////////////////////////////////////////////////////////////////////

	localparam int CFG_SOURCE        = 0;
	localparam int CFG_SIM_ENABLE    = 1;
	localparam int CFG_SIM_CW        = 2;
	localparam int CFG_FLIP_AB       = 3;
	localparam int CFG_SPEED_ENABLE  = 4;
	localparam int CFG_FILTER_ENABLE = 5;
	// filter size field, lsb and width
	localparam int CFG_FILTER_SIZE   = 6;
	localparam int CFG_FILTER_W      = 3;

	// clamp for the speed result
	localparam word_t MAX_SPEED_COUNT = 32'd65535;

	// generator FSM
	typedef enum logic [1:0] {GEN_IDLE, GEN_LOAD, GEN_WAIT, GEN_STEP} gen_state_t;

	// speed measurement FSM
	typedef enum logic [2:0] {
		SPD_IDLE, SPD_WAIT_HIGH, SPD_COUNT, SPD_ACCUM, SPD_STORE
	} speed_state_t;

endpackage

/* verilog/qe_decoder.sv */
// quadrature decoder, four counts per cycle, gives count, direction and index pulses
module qe_decoder (
	input  logic clk,
	input  logic reset,
	input  logic a,
	input  logic b,
	input  logic i,
	output logic count_pulse,
	output logic up,
	output logic index_pulse
);

	// position inside one gray cycle
	logic [1:0] pos;
	logic [1:0] prev_pos;
	// signed distance from the last sample
	logic [1:0] step;
	logic       prev_i;
	logic       dir_q;
	logic       step_up;

	// 00 -> 0, 10 -> 1, 11 -> 2, 01 -> 3 for {a, b}
	// so A leading B walks upwards
	assign pos  = {b, a ^ b};
	assign step = pos - prev_pos;

	// +1 forward, -1 backward
	// a step of 2 is a double edge, no count
	assign count_pulse = (step == 2'd1) || (step == 2'd3);
	assign step_up     = (step == 2'd1);

	// direction of this step, else of the last one
	assign up = count_pulse ? step_up : dir_q;

	// index on rising I only
	assign index_pulse = i & ~prev_i;

	// previous sample, one cycle behind the inputs
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			prev_pos <= 2'd0;
			prev_i   <= 1'b0;
			// forward until the first step is seen
			dir_q    <= 1'b1;
		end else begin
			prev_pos <= pos;
			prev_i   <= i;
			if (count_pulse) begin
				dir_q <= step_up;
			end
		end
	end

endmodule

/* verilog/qe_generator.sv */
// encoder simulator, produces quadrature A/B and an index pulse once per revolution
module qe_generator import qe_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  enable,
	input  logic  cw,
	input  word_t phase_time,
	input  word_t counts_per_rev,
	output logic  sim_a,
	output logic  sim_b,
	output logic  sim_i
);

	gen_state_t state;
	// cycles spent in the current phase
	word_t      timer;
	// full quadrature cycles since last index
	word_t      cycles;
	logic [1:0] phase;

	// phase 0..3, order reversed for ccw
	always_comb begin
		case (phase)
			2'd1:    {sim_a, sim_b} = cw ? 2'b10 : 2'b01;
			2'd2:    {sim_a, sim_b} = 2'b11;
			2'd3:    {sim_a, sim_b} = cw ? 2'b01 : 2'b10;
			default: {sim_a, sim_b} = 2'b00;
		endcase
	end

	// WAIT covers timer 0 .. phase_time-1
	// STEP is the last cycle of a phase
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state  <= GEN_IDLE;
			timer  <= '0;
			cycles <= '0;
			phase  <= 2'd0;
			sim_i  <= 1'b0;
		end else if (!enable) begin
			// parked at 00 with index low
			state  <= GEN_IDLE;
			timer  <= '0;
			cycles <= '0;
			phase  <= 2'd0;
			sim_i  <= 1'b0;
		end else begin
			case (state)
				GEN_IDLE: state <= GEN_LOAD;
				GEN_LOAD: begin
					timer <= '0;
					state <= (phase_time == '0) ? GEN_STEP : GEN_WAIT;
				end
				GEN_WAIT: begin
					// clamp keeps timer in range if phase_time shrinks
					if (timer + 32'd1 >= phase_time) begin
						timer <= phase_time;
						state <= GEN_STEP;
					end else begin
						timer <= timer + 32'd1;
					end
				end
				GEN_STEP: begin
					phase <= phase + 2'd1;
					timer <= '0;
					state <= (phase_time == '0) ? GEN_STEP : GEN_WAIT;
					// index high for the phase after a full revolution
					sim_i <= (phase == 2'd3) && (counts_per_rev != '0) &&
						(cycles + 32'd1 >= counts_per_rev);
					if (phase == 2'd3) begin
						if ((counts_per_rev != '0) && (cycles + 32'd1 >= counts_per_rev)) begin
							cycles <= '0;
						end else begin
							cycles <= cycles + 32'd1;
						end
					end
				end
				default: state <= GEN_IDLE;
			endcase
		end
	end

	// allowed to settle one cycle after a host write
	a_timer_range: assert property (@(posedge clk) disable iff (!reset)
		(state != GEN_IDLE) && $stable(phase_time) |-> (timer <= phase_time))
		else $error("phase timer above phase_time");

endmodule

/* verilog/qe_speed_measure.sv */
// measures the high time of A in clock cycles, averaged over 2^k periods and clamped
module qe_speed_measure import qe_pkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    enable,
	input  logic                    a,
	input  logic                    filter_enable,
	input  logic [CFG_FILTER_W-1:0] filter_size,
	output word_t                   speed
);

	// room for 16 saturated samples
	localparam int SUM_W = 36;

	speed_state_t      state;
	logic              a_q;
	// high cycles of the current period
	word_t             high_count;
	logic [SUM_W-1:0]  sum;
	logic [4:0]        samples;
	logic [2:0]        k;
	logic [4:0]        target;
	logic [SUM_W-1:0]  avg;

	// sizes above 4 fall back to a single sample
	assign k      = (filter_enable && (filter_size <= 3'd4)) ? filter_size : 3'd0;
	assign target = 5'd1 << k;
	// average by right shift of the sum
	assign avg    = sum >> k;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state      <= SPD_IDLE;
			a_q        <= 1'b0;
			high_count <= '0;
			sum        <= '0;
			samples    <= '0;
			speed      <= '0;
		end else begin
			a_q <= a;
			if (!enable) begin
				// last result stays readable
				state   <= SPD_IDLE;
				sum     <= '0;
				samples <= '0;
			end else begin
				case (state)
					SPD_IDLE: state <= SPD_WAIT_HIGH;
					SPD_WAIT_HIGH: begin
						// rising A, first high cycle counts
						if (a && !a_q) begin
							high_count <= 32'd1;
							state      <= SPD_COUNT;
						end
					end
					SPD_COUNT: begin
						if (a) begin
							// saturate on a stalled encoder
							if (high_count != '1) begin
								high_count <= high_count + 32'd1;
							end
						end else begin
							state <= SPD_ACCUM;
						end
					end
					SPD_ACCUM: begin
						sum     <= sum + SUM_W'(high_count);
						samples <= samples + 5'd1;
						state   <= (samples + 5'd1 >= target) ? SPD_STORE : SPD_WAIT_HIGH;
					end
					SPD_STORE: begin
						speed   <= (avg > SUM_W'(MAX_SPEED_COUNT)) ? MAX_SPEED_COUNT : avg[31:0];
						sum     <= '0;
						samples <= '0;
						state   <= SPD_WAIT_HIGH;
					end
					default: state <= SPD_IDLE;
				endcase
			end
		end
	end

endmodule

/* verilog/qe_channel.sv */
// one encoder channel with its registers, input select, position and turns counters
module qe_channel import qe_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  qe_reg_t reg_offset,
	input  logic    write_sel,
	input  logic    read_sel,
	input  word_t   write_data,
	input  logic    ext_a,
	input  logic    ext_b,
	input  logic    ext_i,
	output word_t   reg_data
);

	// host registers
	word_t cfg;
	word_t phase_time;
	word_t counts_per_rev;
	// signed two's complement counters
	word_t count;
	word_t turns;
	word_t speed;

	// {i, b, a} bundles
	logic [2:0] sync_1;
	logic [2:0] sync_2;
	logic [2:0] src_abi;

	logic       sim_a;
	logic       sim_b;
	logic       sim_i;
	logic       sel_a;
	logic       sel_b;
	logic       sel_i;
	logic       count_pulse;
	logic       up;
	logic       index_pulse;
	logic [5:0] status;
	word_t      reg_value;

	//////////////////////////////////////////////////////////////////////
	// register file
	//////////////////////////////////////////////////////////////////////

	// only the three setup registers are writable
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			cfg            <= '0;
			phase_time     <= '0;
			counts_per_rev <= '0;
		end else if (write_sel) begin
			case (reg_offset)
				REG_PHASE_TIME:     phase_time     <= write_data;
				REG_COUNTS_PER_REV: counts_per_rev <= write_data;
				REG_CONFIG:         cfg            <= write_data;
				default:            ;
			endcase
		end
	end

	assign status = {sel_i, sel_b, sel_a, sync_2};

	// combinational read mux
	always_comb begin
		case (reg_offset)
			REG_COUNT:          reg_value = count;
			REG_TURNS:          reg_value = turns;
			REG_SPEED:          reg_value = speed;
			REG_PHASE_TIME:     reg_value = phase_time;
			REG_COUNTS_PER_REV: reg_value = counts_per_rev;
			REG_CONFIG:         reg_value = cfg;
			REG_STATUS:         reg_value = {26'd0, status};
			default:            reg_value = '0;
		endcase
	end

	// zero unless this channel is read
	assign reg_data = read_sel ? reg_value : '0;

	//////////////////////////////////////////////////////////////////////
	// input path
	//////////////////////////////////////////////////////////////////////

	// two flop synchronizer per external line
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			sync_1 <= '0;
			sync_2 <= '0;
		end else begin
			sync_1 <= {ext_i, ext_b, ext_a};
			sync_2 <= sync_1;
		end
	end

	// simulator or synced pins
	assign src_abi = cfg[CFG_SOURCE] ? {sim_i, sim_b, sim_a} : sync_2;

	// optional A/B swap, index untouched
	assign sel_a = cfg[CFG_FLIP_AB] ? src_abi[1] : src_abi[0];
	assign sel_b = cfg[CFG_FLIP_AB] ? src_abi[0] : src_abi[1];
	assign sel_i = src_abi[2];

	qe_generator u_generator (
		.clk           (clk),
		.reset         (reset),
		.enable        (cfg[CFG_SIM_ENABLE]),
		.cw            (cfg[CFG_SIM_CW]),
		.phase_time    (phase_time),
		.counts_per_rev(counts_per_rev),
		.sim_a         (sim_a),
		.sim_b         (sim_b),
		.sim_i         (sim_i)
	);

	qe_decoder u_decoder (
		.clk        (clk),
		.reset      (reset),
		.a          (sel_a),
		.b          (sel_b),
		.i          (sel_i),
		.count_pulse(count_pulse),
		.up         (up),
		.index_pulse(index_pulse)
	);

	qe_speed_measure u_speed_measure (
		.clk          (clk),
		.reset        (reset),
		.enable       (cfg[CFG_SPEED_ENABLE]),
		.a            (sel_a),
		.filter_enable(cfg[CFG_FILTER_ENABLE]),
		.filter_size  (cfg[CFG_FILTER_SIZE +: CFG_FILTER_W]),
		.speed        (speed)
	);

	//////////////////////////////////////////////////////////////////////
	// position and turns
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			count <= '0;
			turns <= '0;
		end else begin
			if (count_pulse) begin
				count <= up ? count + 32'd1 : count - 32'd1;
			end
			// turns follow the current direction
			if (index_pulse) begin
				turns <= up ? turns + 32'd1 : turns - 32'd1;
			end
		end
	end

	// host never writes the unused slot
	a_no_unused_write: assert property (
		@(posedge clk) disable iff (!reset) write_sel |-> (reg_offset != REG_UNUSED))
		else $error("write to unused register offset");

endmodule

/* verilog/qe_bus_interface.sv */
// host bus front end, splits the address into channel select and register offset, returns read data
module qe_bus_interface import qe_pkg::*; #(
	parameter int NUM_CHANNELS = 2
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    write,
	input  logic                    read,
	input  logic [ADDR_W-1:0]       address,
	input  word_t                   write_data,
	input  word_t                   reg_data [NUM_CHANNELS],
	output qe_reg_t                 reg_offset,
	output logic [NUM_CHANNELS-1:0] write_sel,
	output logic [NUM_CHANNELS-1:0] read_sel,
	output word_t                   channel_write_data,
	output word_t                   read_data,
	output logic                    read_valid
);

	localparam int CHAN_W = ADDR_W - OFFSET_W;

	logic [CHAN_W-1:0]       chan_num;
	logic [NUM_CHANNELS-1:0] chan_hit;
	word_t                   read_mux;

	// upper bits pick the channel, lower bits the register
	assign chan_num   = address[ADDR_W-1:OFFSET_W];
	assign reg_offset = qe_reg_t'(address[OFFSET_W-1:0]);

	// one-hot hit, only channels that exist
	always_comb begin
		for (int c = 0; c < NUM_CHANNELS; c++) begin
			chan_hit[c] = (chan_num == CHAN_W'(c));
		end
	end

	assign write_sel          = chan_hit & {NUM_CHANNELS{write}};
	assign read_sel           = chan_hit & {NUM_CHANNELS{read}};
	assign channel_write_data = write_data;

	// unselected channels drive zero so a plain OR picks the data
	always_comb begin
		read_mux = '0;
		for (int c = 0; c < NUM_CHANNELS; c++) begin
			read_mux = read_mux | reg_data[c];
		end
	end

	// read_valid one cycle after the strobe
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			read_valid <= 1'b0;
		end else begin
			read_valid <= read;
		end
	end

	// data captured at the strobe edge
	always_ff @(posedge clk) begin
		if (read) begin
			read_data <= read_mux;
		end
	end

	// single host, one strobe at a time
	a_one_strobe: assert property (@(posedge clk) disable iff (!reset) !(read && write))
		else $error("read and write strobes high together");

endmodule

/* verilog/qe_subsystem.sv */
// top level of the encoder subsystem, host register bus in front of NUM_CHANNELS encoder channels
module qe_subsystem import qe_pkg::*; #(
	parameter int NUM_CHANNELS = 2
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    write,
	input  logic                    read,
	input  logic [ADDR_W-1:0]       address,
	input  word_t                   write_data,
	output word_t                   read_data,
	output logic                    read_valid,
	input  logic [NUM_CHANNELS-1:0] ext_a,
	input  logic [NUM_CHANNELS-1:0] ext_b,
	input  logic [NUM_CHANNELS-1:0] ext_i
);

	// bus side of every channel
	qe_reg_t                 reg_offset;
	logic [NUM_CHANNELS-1:0] write_sel;
	logic [NUM_CHANNELS-1:0] read_sel;
	word_t                   channel_write_data;
	word_t                   reg_data [NUM_CHANNELS];

	// address decode and read data register
	qe_bus_interface #(
		.NUM_CHANNELS(NUM_CHANNELS)
	) u_bus_interface (
		.clk               (clk),
		.reset             (reset),
		.write             (write),
		.read              (read),
		.address           (address),
		.write_data        (write_data),
		.reg_data          (reg_data),
		.reg_offset        (reg_offset),
		.write_sel         (write_sel),
		.read_sel          (read_sel),
		.channel_write_data(channel_write_data),
		.read_data         (read_data),
		.read_valid        (read_valid)
	);

	// channels are peers on the one register bus
	for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_channel
		qe_channel u_channel (
			.clk       (clk),
			.reset     (reset),
			.reg_offset(reg_offset),
			.write_sel (write_sel[c]),
			.read_sel  (read_sel[c]),
			.write_data(channel_write_data),
			.ext_a     (ext_a[c]),
			.ext_b     (ext_b[c]),
			.ext_i     (ext_i[c]),
			.reg_data  (reg_data[c])
		);
	end

endmodule

/* verification/qe_checker.sv */
// testbench checker, models registers and decoder from the host and ext ports, compares reads
module qe_checker import qe_pkg::*; #(
	parameter int NUM_CHANNELS = 2
) (
	input logic                    clk,
	input logic                    reset,
	input logic                    write,
	input logic                    read,
	input logic [ADDR_W-1:0]       address,
	input word_t                   write_data,
	input word_t                   read_data,
	input logic                    read_valid,
	input logic [NUM_CHANNELS-1:0] ext_a,
	input logic [NUM_CHANNELS-1:0] ext_b,
	input logic [NUM_CHANNELS-1:0] ext_i,
	input int                      test_num,
	input logic [8*16-1:0]         test_name,
	input logic                    test_done
);

	// register and decoder model per channel
	word_t      cfg_m [NUM_CHANNELS];
	word_t      pt_m [NUM_CHANNELS];
	word_t      cpr_m [NUM_CHANNELS];
	word_t      count_m [NUM_CHANNELS];
	word_t      turns_m [NUM_CHANNELS];
	logic [2:0] sync1_m [NUM_CHANNELS];
	logic [2:0] sync2_m [NUM_CHANNELS];
	logic [1:0] prev_pos_m [NUM_CHANNELS];
	logic       prev_i_m [NUM_CHANNELS];
	logic       dir_m [NUM_CHANNELS];
	// false once the simulator has driven the counters
	logic       count_known [NUM_CHANNELS];
	// last count and turns read, for the direction test
	logic       have_prev [NUM_CHANNELS];
	word_t      prev_count [NUM_CHANNELS];
	word_t      prev_turns [NUM_CHANNELS];

	// read in flight
	logic  pend;
	int    pend_ch;
	int    pend_off;
	word_t pend_exp;
	logic  pend_cmp;

	int test_checks;
	int test_errors;
	int total_checks;
	int total_errors;
	int tests_run;

	int         ch;
	int         off;
	logic [2:0] s;
	logic [1:0] pos;
	logic [1:0] step;

	// {i, b, a} after source select and swap, external source only
	function automatic logic [2:0] sel_bits(input int c);
		logic [2:0] v;
		v = sync2_m[c];
		if (cfg_m[c][CFG_FLIP_AB]) begin
			v = {v[2], v[0], v[1]};
		end
		return v;
	endfunction

	// place of {a, b} in the forward order 00, 10, 11, 01
	function automatic logic [1:0] gray_pos(input logic a, input logic b);
		case ({a, b})
			2'b10:   return 2'd1;
			2'b11:   return 2'd2;
			2'b01:   return 2'd3;
			default: return 2'd0;
		endcase
	endfunction

	// high time of A is two phases
	function automatic word_t speed_expect(input word_t pt);
		longint e;
		e = 2 * (longint'(pt) + 1);
		return (e > longint'(MAX_SPEED_COUNT)) ? MAX_SPEED_COUNT : word_t'(e);
	endfunction

	task automatic fail_value(input word_t exp, input word_t act);
		$display("Mismatch test %0s ch %0d offset %0d expected %0h actual %0h",
			test_name, pend_ch, pend_off, exp, act);
		test_errors++;
	endtask

	task automatic report_error(input string msg);
		$display("Error in test %0s: %s", test_name, msg);
		test_errors++;
	endtask

	// compares the data of the read that completes now
	task automatic check_response();
		if (pend_cmp) begin
			test_checks++;
			if (read_data !== pend_exp) begin
				fail_value(pend_exp, read_data);
			end
		end
		// simulator direction, count and turns must move with cw
		if (test_num == 4 && pend_ch < NUM_CHANNELS && pend_off <= 1) begin
			if (pend_off == 0 && have_prev[pend_ch]) begin
				test_checks++;
				if (cfg_m[pend_ch][CFG_SIM_CW] ?
					$signed(read_data) <= $signed(prev_count[pend_ch]) :
					$signed(read_data) >= $signed(prev_count[pend_ch])) begin
					report_error("count did not move in the simulator direction");
				end
			end
			if (pend_off == 1 && have_prev[pend_ch]) begin
				test_checks++;
				if (cfg_m[pend_ch][CFG_SIM_CW] ?
					$signed(read_data) <= $signed(prev_turns[pend_ch]) :
					$signed(read_data) >= $signed(prev_turns[pend_ch])) begin
					report_error("turns did not move in step with the count");
				end
			end
			if (pend_off == 0) begin
				prev_count[pend_ch] = read_data;
			end else begin
				prev_turns[pend_ch] = read_data;
				have_prev[pend_ch]  = 1'b1;
			end
		end
	endtask

	always @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int c = 0; c < NUM_CHANNELS; c++) begin
				cfg_m[c]      = '0;
				pt_m[c]       = '0;
				cpr_m[c]      = '0;
				count_m[c]    = '0;
				turns_m[c]    = '0;
				sync1_m[c]    = '0;
				sync2_m[c]    = '0;
				prev_pos_m[c] = '0;
				prev_i_m[c]   = 1'b0;
				dir_m[c]      = 1'b1;
				count_known[c] = 1'b1;
				have_prev[c]  = 1'b0;
			end
			pend = 1'b0;
		end else begin
			// response of the read one cycle back
			if (read_valid !== pend) begin
				report_error("read_valid did not follow the read strobe by one cycle");
			end
			if (read_valid && pend) begin
				check_response();
			end

			// expected value from pre-edge model state
			pend = read;
			if (read) begin
				ch       = address[ADDR_W-1:OFFSET_W];
				off      = address[OFFSET_W-1:0];
				pend_ch  = ch;
				pend_off = off;
				pend_exp = '0;
				pend_cmp = 1'b1;
				if (ch < NUM_CHANNELS) begin
					case (off)
						0: begin
							pend_exp = count_m[ch];
							pend_cmp = count_known[ch];
						end
						1: begin
							pend_exp = turns_m[ch];
							pend_cmp = count_known[ch];
						end
						2: begin
							pend_exp = speed_expect(pt_m[ch]);
							pend_cmp = (test_num == 5);
						end
						3: pend_exp = pt_m[ch];
						4: pend_exp = cpr_m[ch];
						5: pend_exp = cfg_m[ch];
						6: begin
							pend_exp = {26'd0, sel_bits(ch), sync2_m[ch]};
							pend_cmp = !cfg_m[ch][CFG_SOURCE];
						end
						default: pend_exp = '0;
					endcase
				end
			end

			// decoder model, behind a two flop synchronizer
			for (int c = 0; c < NUM_CHANNELS; c++) begin
				s    = sel_bits(c);
				pos  = gray_pos(s[0], s[1]);
				step = pos - prev_pos_m[c];
				if (step == 2'd1 || step == 2'd3) begin
					dir_m[c]   = (step == 2'd1);
					count_m[c] = dir_m[c] ? count_m[c] + 1 : count_m[c] - 1;
				end
				if (s[2] && !prev_i_m[c]) begin
					turns_m[c] = dir_m[c] ? turns_m[c] + 1 : turns_m[c] - 1;
				end
				prev_pos_m[c] = pos;
				prev_i_m[c]   = s[2];
				sync2_m[c]    = sync1_m[c];
				sync1_m[c]    = {ext_i[c], ext_b[c], ext_a[c]};
				if (cfg_m[c][CFG_SOURCE]) begin
					count_known[c] = 1'b0;
				end
			end

			// host writes, after the decoder saw the old config
			ch  = address[ADDR_W-1:OFFSET_W];
			off = address[OFFSET_W-1:0];
			if (write && ch < NUM_CHANNELS) begin
				case (off)
					3: pt_m[ch] = write_data;
					4: cpr_m[ch] = write_data;
					5: begin
						cfg_m[ch]     = write_data;
						have_prev[ch] = 1'b0;
					end
					default: ;
				endcase
			end

			// one line per finished test
			if (test_done) begin
				$display("test %0d %0s: %0d checks, %0d errors, %s", test_num, test_name,
					test_checks, test_errors, (test_errors == 0) ? "ok" : "bad");
				total_checks = total_checks + test_checks;
				total_errors = total_errors + test_errors;
				tests_run    = tests_run + 1;
				test_checks  = 0;
				test_errors  = 0;
			end
		end
	end

	initial begin
		test_checks  = 0;
		test_errors  = 0;
		total_checks = 0;
		total_errors = 0;
		tests_run    = 0;
	end

endmodule

/* verification/tb_qe.sv */
// testbench top for the encoder subsystem, drives seeded random host and encoder stimulus
module tb_qe import qe_pkg::*; ();

	localparam int NUM_CHANNELS = 2;
	localparam int NUM_TESTS = 5;
	// clamp run of the speed test is the longest
	localparam longint LONGEST_TEST_CYCLES = 600000;

	logic                    clk;
	logic                    reset;
	logic                    write;
	logic                    read;
	logic [ADDR_W-1:0]       address;
	word_t                   write_data;
	word_t                   read_data;
	logic                    read_valid;
	logic [NUM_CHANNELS-1:0] ext_a;
	logic [NUM_CHANNELS-1:0] ext_b;
	logic [NUM_CHANNELS-1:0] ext_i;

	int             test_num;
	logic [8*16-1:0] test_name;
	logic           test_done;
	integer         seed;
	logic [1:0]     gpos [NUM_CHANNELS];
	int             ch;
	word_t          pt;
	word_t          val;

	qe_subsystem #(.NUM_CHANNELS(NUM_CHANNELS)) dut (
		.clk(clk), .reset(reset), .write(write), .read(read), .address(address),
		.write_data(write_data), .read_data(read_data), .read_valid(read_valid),
		.ext_a(ext_a), .ext_b(ext_b), .ext_i(ext_i)
	);

	qe_checker #(.NUM_CHANNELS(NUM_CHANNELS)) u_checker (
		.clk(clk), .reset(reset), .write(write), .read(read), .address(address),
		.write_data(write_data), .read_data(read_data), .read_valid(read_valid),
		.ext_a(ext_a), .ext_b(ext_b), .ext_i(ext_i), .test_num(test_num),
		.test_name(test_name), .test_done(test_done)
	);

	always #5 clk = ~clk;

	// ends at 1 time unit past a rising edge
	task automatic wait_cycles(input longint n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic bus_write(input int ch_num, input int off, input word_t data);
		@(posedge clk);
		#1;
		write      = 1'b1;
		address    = ADDR_W'(ch_num * REGS_PER_CHANNEL + off);
		write_data = data;
		@(posedge clk);
		#1;
		write = 1'b0;
	endtask

	// one strobe, then wait for read_valid with a short timeout
	task automatic bus_read(input int ch_num, input int off);
		int tries;
		tries = 0;
		@(posedge clk);
		#1;
		read    = 1'b1;
		address = ADDR_W'(ch_num * REGS_PER_CHANNEL + off);
		@(posedge clk);
		#1;
		read = 1'b0;
		while (!read_valid && tries < 4) begin
			@(posedge clk);
			#1;
			tries++;
		end
	endtask

	task automatic end_test();
		@(posedge clk);
		#1;
		test_done = 1'b1;
		@(posedge clk);
		#1;
		test_done = 1'b0;
	endtask

	// gray position to {a, b}, A leads B going up
	function automatic logic [1:0] gray_ab(input logic [1:0] p);
		case (p)
			2'd1:    return 2'b10;
			2'd2:    return 2'b11;
			2'd3:    return 2'b01;
			default: return 2'b00;
		endcase
	endfunction

	// simulator on, wait for 2^k falling edges of A plus slack, read speed
	task automatic speed_run(input int c, input word_t ptime, input bit fe, input int k);
		bus_write(c, REG_CONFIG, '0);
		bus_write(c, REG_PHASE_TIME, ptime);
		bus_write(c, REG_CONFIG, word_t'((1 << CFG_SOURCE) | (1 << CFG_SIM_ENABLE) |
			(1 << CFG_SIM_CW) | (1 << CFG_SPEED_ENABLE) | (fe << CFG_FILTER_ENABLE) |
			(k << CFG_FILTER_SIZE)));
		wait_cycles(((longint'(1) << k) + 2) * 4 * (longint'(ptime) + 1) + 20);
		bus_read(c, REG_SPEED);
	endtask

	initial begin
		clk        = 1'b0;
		reset      = 1'b0;
		write      = 1'b0;
		read       = 1'b0;
		address    = '0;
		write_data = '0;
		ext_a      = '0;
		ext_b      = '0;
		ext_i      = '0;
		test_num   = 0;
		test_name  = "reset";
		test_done  = 1'b0;
		seed       = 29;
		gpos[0]    = 2'd0;
		gpos[1]    = 2'd0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b1;

		////////////////////////////////////////////////////////////////////
		// register access
		test_num  = 1;
		test_name = "reg_access";
		for (int n = 0; n < 20; n++) begin
			ch  = $random(seed) & 1;
			val = $random(seed);
			case ($random(seed) & 3)
				0: bus_write(ch, REG_PHASE_TIME, val);
				1: bus_write(ch, REG_COUNTS_PER_REV, val);
				// external source, simulator and speed off
				default: bus_write(ch, REG_CONFIG, val & ~word_t'(32'h13));
			endcase
			bus_read(ch, REG_PHASE_TIME);
			bus_read(ch, REG_COUNTS_PER_REV);
			bus_read(ch, REG_CONFIG);
			bus_read(ch, 7);
			// channels that do not exist
			bus_write(2 + ($random(seed) & 3), REG_PHASE_TIME, $random(seed));
			bus_read(2 + ($random(seed) & 3), $random(seed) & 7);
		end
		bus_write(0, REG_CONFIG, '0);
		bus_write(1, REG_CONFIG, '0);
		end_test();

		////////////////////////////////////////////////////////////////////
		// external counting
		test_num  = 2;
		test_name = "ext_count";
		for (int n = 0; n < 48; n++) begin
			ch       = $random(seed) & 1;
			gpos[ch] = ($random(seed) & 1) ? gpos[ch] + 2'd1 : gpos[ch] - 2'd1;
			{ext_a[ch], ext_b[ch]} = gray_ab(gpos[ch]);
			if (($random(seed) & 7) == 0) begin
				ext_i[ch] = 1'b1;
			end
			wait_cycles(4 + ($random(seed) & 3));
			ext_i[ch] = 1'b0;
			wait_cycles(4);
			if (n % 8 == 7) begin
				for (int c = 0; c < NUM_CHANNELS; c++) begin
					bus_read(c, REG_COUNT);
					bus_read(c, REG_TURNS);
				end
			end
		end
		end_test();

		////////////////////////////////////////////////////////////////////
		// A/B swap and status
		test_num  = 3;
		test_name = "swap_status";
		for (int n = 0; n < 12; n++) begin
			ext_a = $random(seed);
			ext_b = $random(seed);
			ext_i = $random(seed);
			wait_cycles(6);
			ch = $random(seed) & 1;
			bus_write(ch, REG_CONFIG, word_t'(($random(seed) & 1) << CFG_FLIP_AB));
			wait_cycles(4);
			for (int c = 0; c < NUM_CHANNELS; c++) begin
				bus_read(c, REG_STATUS);
				bus_read(c, REG_COUNT);
				bus_read(c, REG_TURNS);
			end
		end
		end_test();

		////////////////////////////////////////////////////////////////////
		// simulator direction
		test_num  = 4;
		test_name = "sim_direction";
		for (int c = 0; c < NUM_CHANNELS; c++) begin
			for (int cw = 1; cw >= 0; cw--) begin
				bus_write(c, REG_CONFIG, '0);
				bus_write(c, REG_PHASE_TIME, $random(seed) & 7);
				bus_write(c, REG_COUNTS_PER_REV, 1 + ($random(seed) & 1));
				bus_write(c, REG_CONFIG, word_t'((1 << CFG_SOURCE) | (1 << CFG_SIM_ENABLE) |
					(cw << CFG_SIM_CW)));
				wait_cycles(20);
				for (int r = 0; r < 3; r++) begin
					bus_read(c, REG_COUNT);
					bus_read(c, REG_TURNS);
					wait_cycles(200);
				end
			end
		end
		end_test();

		////////////////////////////////////////////////////////////////////
		// speed measurement
		test_num  = 5;
		test_name = "speed";
		for (int c = 0; c < NUM_CHANNELS; c++) begin
			speed_run(c, $random(seed) & 31, 1'b0, 0);
			speed_run(c, $random(seed) & 15, 1'b1, ($random(seed) & 7) % 5);
		end
		pt = 32768 + ($random(seed) & 255);
		speed_run(0, pt, 1'b0, 0);
		end_test();

		wait_cycles(2);
		$display("tests %0d, checks %0d, errors %0d", u_checker.tests_run,
			u_checker.total_checks, u_checker.total_errors);
		if (u_checker.total_errors == 0 && u_checker.total_checks > 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// watchdog sized from the longest test
	initial begin
		#(NUM_TESTS * LONGEST_TEST_CYCLES * 10 + 100000);
		$display("timeout: the run did not finish in time, stuck in test %0s", test_name);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* vlog.f */
verilog/qe_pkg.sv
verilog/qe_decoder.sv
verilog/qe_generator.sv
verilog/qe_speed_measure.sv
verilog/qe_channel.sv
verilog/qe_bus_interface.sv
verilog/qe_subsystem.sv
verification/qe_checker.sv
verification/tb_qe.sv
